/* files.f */
+incdir+include
rtl/svc_pkg.sv
rtl/svc_cmd_decoder.sv
rtl/svc_reset_sequencer.sv
rtl/svc_write_filter.sv
rtl/svc_top.sv
test/tb_svc_top.sv

/* rtl/svc_cmd_decoder.sv */
// Service command decoder
// Accepts byte-wide service commands on a valid/ready channel and keeps
// the sticky override state for the fuse and lifecycle subsystem. A domain
// reset command is passed to the reset sequencer as a one-cycle request

`timescale 1ns/10ps

module svc_cmd_decoder (
  input  logic                clk,
  input  logic                cptra_rst_b,
  input  logic                cmd_valid_i,
  input  svc_pkg::svc_cmd_e   cmd_i,
  input  logic                rst_active_i,
  output logic                cmd_ready_o,
  output svc_pkg::svc_ovr_t   ovr_o,
  output logic                rst_req_o
);

  logic              cmd_accept;
  svc_pkg::svc_ovr_t ovr_q;
  svc_pkg::svc_ovr_t ovr_d;

  // --------------------------------------------------------------------------
  // Handshake
  // --------------------------------------------------------------------------

  // Commands stall while the domain is held in reset
  assign cmd_ready_o = ~rst_active_i;
  assign cmd_accept  = cmd_valid_i & cmd_ready_o;

  // The sequencer starts on the accepting edge, so the request is not registered
  assign rst_req_o = cmd_accept && (cmd_i == svc_pkg::CMD_DOMAIN_RESET);

  // --------------------------------------------------------------------------
  // Override next state
  // --------------------------------------------------------------------------

  always_comb begin
    ovr_d = ovr_q;
    if (cmd_accept) begin
      case (cmd_i)
        svc_pkg::CMD_USER_CORE: begin
          ovr_d.user_ovr_en  = 1'b1;
          ovr_d.user_sel_mcu = 1'b0;
        end
        svc_pkg::CMD_USER_MCU: begin
          ovr_d.user_ovr_en  = 1'b1;
          ovr_d.user_sel_mcu = 1'b1;
        end
        svc_pkg::CMD_USER_RELEASE: begin
          ovr_d.user_ovr_en = 1'b0;
        end
        svc_pkg::CMD_ZEROIZE_SET: begin
          ovr_d.zeroize_ovr_en = 1'b1;
          ovr_d.zeroize_val    = 1'b1;
        end
        svc_pkg::CMD_ZEROIZE_CLEAR: begin
          ovr_d.zeroize_ovr_en = 1'b1;
          ovr_d.zeroize_val    = 1'b0;
        end
        svc_pkg::CMD_ZEROIZE_RELEASE: begin
          ovr_d.zeroize_ovr_en = 1'b0;
        end
        // Escalation has no release path, only cptra_rst_b clears it
        svc_pkg::CMD_ESCALATE: begin
          ovr_d.escalate = 1'b1;
        end
        svc_pkg::CMD_CLK_500: begin
          ovr_d.clk_sel = svc_pkg::CLK_SEL_500;
        end
        svc_pkg::CMD_CLK_160: begin
          ovr_d.clk_sel = svc_pkg::CLK_SEL_160;
        end
        svc_pkg::CMD_CLK_400: begin
          ovr_d.clk_sel = svc_pkg::CLK_SEL_400;
        end
        svc_pkg::CMD_CLK_1000: begin
          ovr_d.clk_sel = svc_pkg::CLK_SEL_1000;
        end
        svc_pkg::CMD_FAULT_BUS_ECC: begin
          ovr_d.ecc_fault_en = 1'b1;
        end
        svc_pkg::CMD_SVA_DISABLE: begin
          ovr_d.sva_disable = 1'b1;
        end
        svc_pkg::CMD_SVA_ENABLE: begin
          ovr_d.sva_disable = 1'b0;
        end
        default: begin
          // Domain reset and unknown codes leave the overrides alone
        end
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // Override register
  // --------------------------------------------------------------------------

  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      ovr_q         <= '0;
      ovr_q.clk_sel <= svc_pkg::CLK_SEL_500;
    end else begin
      ovr_q <= ovr_d;
    end
  end

  assign ovr_o = ovr_q;

  // A new domain reset is never requested while the sequencer is busy
  a_no_req_while_active: assert property (
    @(posedge clk) disable iff (!cptra_rst_b)
    $rose(rst_req_o) |-> !rst_active_i
  );

endmodule

/* rtl/svc_pkg.sv */
// Test-service controller package
// Command codes, clock select encoding, the override state and the
// fuse-controller write request format used by all service blocks

package svc_pkg;

  // --------------------------------------------------------------------------
  // Constants
  // --------------------------------------------------------------------------

  // Fuse controller DAI write address that the bus ECC fault targets
  localparam logic [31:0] SVC_FAULT_ADDR = 32'h7000_0068;

  // Length of the fuse and lifecycle domain reset in clock cycles
  localparam int unsigned SVC_RST_CYCLES = 11;

  // Counter width, large enough to hold SVC_RST_CYCLES - 1
  localparam int unsigned SVC_RST_CNT_W = 4;

  // --------------------------------------------------------------------------
  // Service commands
  // --------------------------------------------------------------------------

  // Codes not listed here are accepted by the decoder and ignored
  typedef enum logic [7:0] {
    CMD_USER_CORE       = 8'h01,
    CMD_USER_MCU        = 8'h02,
    CMD_USER_RELEASE    = 8'h03,
    CMD_ZEROIZE_SET     = 8'h04,
    CMD_ZEROIZE_CLEAR   = 8'h05,
    CMD_ZEROIZE_RELEASE = 8'h06,
    CMD_ESCALATE        = 8'h07,
    CMD_CLK_500         = 8'h08,
    CMD_CLK_160         = 8'h09,
    CMD_CLK_400         = 8'h0A,
    CMD_CLK_1000        = 8'h0B,
    CMD_FAULT_BUS_ECC   = 8'h0C,
    CMD_DOMAIN_RESET    = 8'h10,
    CMD_SVA_DISABLE     = 8'h11,
    CMD_SVA_ENABLE      = 8'h12
  } svc_cmd_e;

  // External clock frequency select
  typedef enum logic [1:0] {
    CLK_SEL_500  = 2'd0,
    CLK_SEL_160  = 2'd1,
    CLK_SEL_400  = 2'd2,
    CLK_SEL_1000 = 2'd3
  } svc_clk_sel_e;

  // --------------------------------------------------------------------------
  // Structures
  // --------------------------------------------------------------------------

  // Sticky override state held by the command decoder
  typedef struct packed {
    logic         user_ovr_en;
    logic         user_sel_mcu;   // MCU strap when set, core strap when clear
    logic         zeroize_ovr_en;
    logic         zeroize_val;
    logic         escalate;
    svc_clk_sel_e clk_sel;
    logic         ecc_fault_en;
    logic         sva_disable;
  } svc_ovr_t;

  // Write request toward the fuse controller
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] user;
  } svc_wr_req_t;

endpackage

/* rtl/svc_reset_sequencer.sv */
// Domain reset sequencer
// Holds the fuse and lifecycle domain in reset for a fixed number of
// cycles after a request and reports when the hold is in progress

`timescale 1ns/10ps

module svc_reset_sequencer (
  input  logic clk,
  input  logic cptra_rst_b,
  input  logic rst_req_i,
  output logic rst_active_o,
  output logic domain_rst_b_o
);

  localparam logic [svc_pkg::SVC_RST_CNT_W-1:0] CNT_LAST =
    svc_pkg::SVC_RST_CNT_W'(svc_pkg::SVC_RST_CYCLES - 1);

  logic [svc_pkg::SVC_RST_CNT_W-1:0] rst_cnt_q;
  logic                              rst_active_q;
  logic                              domain_rst_b_q;

  // --------------------------------------------------------------------------
  // Counter and active flag
  // --------------------------------------------------------------------------

  // The request edge counts as the first reset cycle
  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      rst_cnt_q      <= '0;
      rst_active_q   <= 1'b0;
      domain_rst_b_q <= 1'b1;
    end else if (rst_req_i && !rst_active_q) begin
      rst_cnt_q      <= '0;
      rst_active_q   <= 1'b1;
      domain_rst_b_q <= 1'b0;
    end else if (rst_active_q) begin
      if (rst_cnt_q == CNT_LAST) begin
        rst_cnt_q      <= '0;
        rst_active_q   <= 1'b0;
        domain_rst_b_q <= 1'b1;
      end else begin
        rst_cnt_q <= rst_cnt_q + 1'b1;
      end
    end
  end

  assign rst_active_o   = rst_active_q;
  assign domain_rst_b_o = domain_rst_b_q;

  // Count stays in range for the whole hold
  a_cnt_in_range: assert property (
    @(posedge clk) disable iff (!cptra_rst_b)
    rst_active_q |-> (rst_cnt_q <= CNT_LAST)
  );

endmodule

/* rtl/svc_top.sv */
// Test-service controller top level
// Joins the command decoder, the domain reset sequencer and the write
// filter, and drives the zeroization, escalation, clock select and
// assertion-disable outputs from the override state

`timescale 1ns/10ps

module svc_top (
  input  logic                   clk,
  input  logic                   cptra_rst_b,
  // Service command channel
  input  logic                   cmd_valid_i,
  input  svc_pkg::svc_cmd_e      cmd_i,
  output logic                   cmd_ready_o,
  // Subsystem controls
  input  logic                   zeroize_ppd_i,
  output logic                   zeroize_ppd_o,
  output logic                   escalate_o,
  output svc_pkg::svc_clk_sel_e  clk_sel_o,
  output logic                   sva_disable_o,
  output logic                   domain_rst_b_o,
  // Fuse controller write stream
  input  logic [31:0]            core_user_i,
  input  logic [31:0]            mcu_user_i,
  input  logic                   in_valid_i,
  input  svc_pkg::svc_wr_req_t   in_req_i,
  output logic                   in_ready_o,
  output logic                   out_valid_o,
  input  logic                   out_ready_i,
  output svc_pkg::svc_wr_req_t   out_req_o
);

  svc_pkg::svc_ovr_t ovr;
  logic              rst_req;
  logic              rst_active;

  svc_cmd_decoder svc_cmd_decoder_inst (
    .clk          (clk),
    .cptra_rst_b  (cptra_rst_b),
    .cmd_valid_i  (cmd_valid_i),
    .cmd_i        (cmd_i),
    .rst_active_i (rst_active),
    .cmd_ready_o  (cmd_ready_o),
    .ovr_o        (ovr),
    .rst_req_o    (rst_req)
  );

  svc_reset_sequencer svc_reset_sequencer_inst (
    .clk            (clk),
    .cptra_rst_b    (cptra_rst_b),
    .rst_req_i      (rst_req),
    .rst_active_o   (rst_active),
    .domain_rst_b_o (domain_rst_b_o)
  );

  svc_write_filter svc_write_filter_inst (
    .clk         (clk),
    .cptra_rst_b (cptra_rst_b),
    .ovr_i       (ovr),
    .hold_i      (rst_active),
    .core_user_i (core_user_i),
    .mcu_user_i  (mcu_user_i),
    .in_valid_i  (in_valid_i),
    .in_req_i    (in_req_i),
    .in_ready_o  (in_ready_o),
    .out_ready_i (out_ready_i),
    .out_valid_o (out_valid_o),
    .out_req_o   (out_req_o)
  );

  // Override wins when enabled, otherwise the pad value passes straight through
  assign zeroize_ppd_o = ovr.zeroize_ovr_en ? ovr.zeroize_val : zeroize_ppd_i;

  assign escalate_o    = ovr.escalate;
  assign clk_sel_o     = ovr.clk_sel;
  assign sva_disable_o = ovr.sva_disable;

endmodule

/* rtl/svc_write_filter.sv */
// Fuse controller write filter
// Zero-latency valid/ready pass-through for write requests. It can
// replace the AXI user field with a strap, flip data bit 0 at the fault
// address to provoke a bus ECC error, and block the stream while the
// fuse and lifecycle domain is held in reset

`timescale 1ns/10ps

module svc_write_filter (
  input  logic                 clk,
  input  logic                 cptra_rst_b,
  input  svc_pkg::svc_ovr_t    ovr_i,
  input  logic                 hold_i,
  input  logic [31:0]          core_user_i,
  input  logic [31:0]          mcu_user_i,
  input  logic                 in_valid_i,
  input  svc_pkg::svc_wr_req_t in_req_i,
  output logic                 in_ready_o,
  input  logic                 out_ready_i,
  output logic                 out_valid_o,
  output svc_pkg::svc_wr_req_t out_req_o
);

  logic [31:0] strap_user;
  logic        fault_hit;

  // --------------------------------------------------------------------------
  // Handshake
  // --------------------------------------------------------------------------

  // Both directions are cut while the domain is in reset so that no beat
  // is lost or half-transferred across the reset
  assign out_valid_o = in_valid_i & ~hold_i;
  assign in_ready_o  = out_ready_i & ~hold_i;

  // --------------------------------------------------------------------------
  // Payload
  // --------------------------------------------------------------------------

  assign strap_user = ovr_i.user_sel_mcu ? mcu_user_i : core_user_i;

  // Only a single data bit flips, which the ECC logic sees as a correctable
  // or detectable error depending on the partition
  assign fault_hit = ovr_i.ecc_fault_en && (in_req_i.addr == svc_pkg::SVC_FAULT_ADDR);

  always_comb begin
    out_req_o = in_req_i;
    if (ovr_i.user_ovr_en) begin
      out_req_o.user = strap_user;
    end
    if (fault_hit) begin
      out_req_o.data[0] = ~in_req_i.data[0];
    end
  end

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------

  // No beat leaves the filter during the reset hold
  a_no_valid_in_hold: assert property (
    @(posedge clk) disable iff (!cptra_rst_b)
    hold_i |-> !out_valid_o
  );

endmodule

/* run.sh */
#!/usr/bin/env bash
# Builds the test-service controller testbench with Verilator and runs it.
# The exit status is the simulator's, nonzero on any failed check.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_svc_top \
  -f files.f \
  --Mdir obj_dir \
  -o sim_tb_svc_top

./obj_dir/sim_tb_svc_top

/* include/svc_tb_params.svh */
// Test-service controller testbench constants
// Seed, clock, test lengths, watchdog budget and strap values

`ifndef SVC_TB_PARAMS_SVH
`define SVC_TB_PARAMS_SVH

// Random seed for addresses, data and commands
localparam logic [31:0] TB_SEED = 32'h6f9a_d31e;

// Clock period in ns and reset length in cycles
localparam int unsigned TB_CLK_PERIOD = 20;
localparam int unsigned TB_RST_CYCLES = 8;

// Test lengths
localparam int unsigned TB_N_USER_WR  = 40;
localparam int unsigned TB_N_FAULT_WR = 40;
localparam int unsigned TB_N_FLAG_CMD = 60;
localparam int unsigned TB_N_CLK_CMD  = 40;
localparam int unsigned TB_N_DOM_RST  = 6;
localparam int unsigned TB_N_BP_WR    = 200;

// Upper bound on cycles, with slack for stalls and reset holds
localparam int unsigned TB_MAX_CYCLES =
  8 * (TB_N_USER_WR + TB_N_FAULT_WR + TB_N_FLAG_CMD + TB_N_CLK_CMD + TB_N_BP_WR) +
  40 * TB_N_DOM_RST + 200;

// Watchdog time in ns
localparam longint unsigned TB_WATCHDOG_NS = TB_MAX_CYCLES * TB_CLK_PERIOD;

// AXI user straps for the core and the MCU
localparam logic [31:0] TB_CORE_USER = 32'hC0DE_0001;
localparam logic [31:0] TB_MCU_USER  = 32'h4D43_0002;

`endif

/* test/tb_svc_top.sv */
// Test-service controller testbench
// Drives service commands and fuse-controller writes into svc_top, keeps a
// reference model of the override rules and compares every output with
// concurrent assertions

`timescale 1ns/10ps

module tb_svc_top;

  `include "svc_tb_params.svh"

  logic                 clk;
  logic                 cptra_rst_b;
  logic                 cmd_valid_i;
  logic [7:0]           cmd_code;
  logic                 cmd_ready_o;
  logic                 zeroize_ppd_i;
  logic                 zeroize_ppd_o;
  logic                 escalate_o;
  svc_pkg::svc_clk_sel_e clk_sel_o;
  logic                 sva_disable_o;
  logic                 domain_rst_b_o;
  logic                 in_valid_i;
  svc_pkg::svc_wr_req_t in_req_i;
  logic                 in_ready_o;
  logic                 out_valid_o;
  logic                 out_ready_i;
  svc_pkg::svc_wr_req_t out_req_o;

  logic                 bp_en;
  string                test_name;

  // Reference model state
  logic                 m_user_en;
  logic                 m_user_mcu;
  logic                 m_zero_en;
  logic                 m_zero_val;
  logic                 m_esc;
  logic [1:0]           m_clk;
  logic                 m_ecc;
  logic                 m_sva;
  int unsigned          m_rst_left;

  logic                 exp_idle;
  logic                 exp_zero;
  svc_pkg::svc_wr_req_t exp_req;

  svc_top svc_top_inst (
    .clk            (clk),
    .cptra_rst_b    (cptra_rst_b),
    .cmd_valid_i    (cmd_valid_i),
    .cmd_i          (svc_pkg::svc_cmd_e'(cmd_code)),
    .cmd_ready_o    (cmd_ready_o),
    .zeroize_ppd_i  (zeroize_ppd_i),
    .zeroize_ppd_o  (zeroize_ppd_o),
    .escalate_o     (escalate_o),
    .clk_sel_o      (clk_sel_o),
    .sva_disable_o  (sva_disable_o),
    .domain_rst_b_o (domain_rst_b_o),
    .core_user_i    (TB_CORE_USER),
    .mcu_user_i     (TB_MCU_USER),
    .in_valid_i     (in_valid_i),
    .in_req_i       (in_req_i),
    .in_ready_o     (in_ready_o),
    .out_valid_o    (out_valid_o),
    .out_ready_i    (out_ready_i),
    .out_req_o      (out_req_o)
  );

  initial begin
    clk = 1'b0;
    forever #(TB_CLK_PERIOD / 2) clk = ~clk;
  end

  // Pad zeroization level and sink back-pressure change every cycle
  always @(posedge clk) begin
    zeroize_ppd_i <= 1'($urandom);
    out_ready_i   <= bp_en ? 1'($urandom) : 1'b1;
  end

  // --------------------------------------------------------------------------
  // Reference model
  // --------------------------------------------------------------------------

  always @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      m_user_en  <= 1'b0;
      m_user_mcu <= 1'b0;
      m_zero_en  <= 1'b0;
      m_zero_val <= 1'b0;
      m_esc      <= 1'b0;
      m_clk      <= 2'd0;
      m_ecc      <= 1'b0;
      m_sva      <= 1'b0;
      m_rst_left <= 0;
    end else begin
      if (m_rst_left != 0) begin
        m_rst_left <= m_rst_left - 1;
      end
      if (cmd_valid_i && m_rst_left == 0) begin
        case (cmd_code)
          8'h01: begin
            m_user_en  <= 1'b1;
            m_user_mcu <= 1'b0;
          end
          8'h02: begin
            m_user_en  <= 1'b1;
            m_user_mcu <= 1'b1;
          end
          8'h03: m_user_en <= 1'b0;
          8'h04: begin
            m_zero_en  <= 1'b1;
            m_zero_val <= 1'b1;
          end
          8'h05: begin
            m_zero_en  <= 1'b1;
            m_zero_val <= 1'b0;
          end
          8'h06: m_zero_en <= 1'b0;
          8'h07: m_esc <= 1'b1;
          8'h08, 8'h09, 8'h0A, 8'h0B: m_clk <= cmd_code[1:0];
          8'h0C: m_ecc <= 1'b1;
          8'h10: m_rst_left <= svc_pkg::SVC_RST_CYCLES;
          8'h11: m_sva <= 1'b1;
          8'h12: m_sva <= 1'b0;
          default: ;
        endcase
      end
    end
  end

  assign exp_idle = (m_rst_left == 0);
  assign exp_zero = m_zero_en ? m_zero_val : zeroize_ppd_i;

  always_comb begin
    exp_req = in_req_i;
    if (m_user_en) begin
      exp_req.user = m_user_mcu ? TB_MCU_USER : TB_CORE_USER;
    end
    if (m_ecc && in_req_i.addr == svc_pkg::SVC_FAULT_ADDR) begin
      exp_req.data = in_req_i.data ^ 32'h1;
    end
  end

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------

  task automatic report_mismatch(input string what, input logic [95:0] exp_v,
                                 input logic [95:0] act_v);
    $display("MISMATCH test=%s signal=%s expected=%0h actual=%0h",
             test_name, what, exp_v, act_v);
    $display("CHECKS FAILED");
    $fatal(1, "output differs from the reference model");
  endtask

  task automatic report_failure(input string what);
    $display("ERROR test=%s: %s", test_name, what);
    $display("CHECKS FAILED");
    $fatal(1, "protocol check failed");
  endtask

  a_ready: assert property (@(posedge clk) disable iff (!cptra_rst_b)
    cmd_ready_o == exp_idle)
    else report_mismatch("cmd_ready_o", 96'($sampled(exp_idle)), 96'($sampled(cmd_ready_o)));

  a_dom_rst: assert property (@(posedge clk) disable iff (!cptra_rst_b)
    domain_rst_b_o == exp_idle)
    else report_mismatch("domain_rst_b_o", 96'($sampled(exp_idle)),
                         96'($sampled(domain_rst_b_o)));

  a_zero: assert property (@(posedge clk) disable iff (!cptra_rst_b)
    zeroize_ppd_o == exp_zero)
    else report_mismatch("zeroize_ppd_o", 96'($sampled(exp_zero)),
                         96'($sampled(zeroize_ppd_o)));

  a_esc: assert property (@(posedge clk) disable iff (!cptra_rst_b)
    escalate_o == m_esc)
    else report_mismatch("escalate_o", 96'($sampled(m_esc)), 96'($sampled(escalate_o)));

  a_clk: assert property (@(posedge clk) disable iff (!cptra_rst_b)
    clk_sel_o == m_clk)
    else report_mismatch("clk_sel_o", 96'($sampled(m_clk)), 96'($sampled(clk_sel_o)));

  a_sva: assert property (@(posedge clk) disable iff (!cptra_rst_b)
    sva_disable_o == m_sva)
    else report_mismatch("sva_disable_o", 96'($sampled(m_sva)),
                         96'($sampled(sva_disable_o)));

  a_out_valid: assert property (@(posedge clk) disable iff (!cptra_rst_b)
    out_valid_o == (in_valid_i && exp_idle))
    else report_mismatch("out_valid_o", 96'($sampled(in_valid_i && exp_idle)),
                         96'($sampled(out_valid_o)));

  a_in_ready: assert property (@(posedge clk) disable iff (!cptra_rst_b)
    in_ready_o == (out_ready_i && exp_idle))
    else report_mismatch("in_ready_o", 96'($sampled(out_ready_i && exp_idle)),
                         96'($sampled(in_ready_o)));

  a_payload: assert property (@(posedge clk) disable iff (!cptra_rst_b)
    out_req_o == exp_req)
    else report_mismatch("out_req_o", $sampled(exp_req), $sampled(out_req_o));

  a_esc_sticky: assert property (@(posedge clk) disable iff (!cptra_rst_b)
    escalate_o |=> escalate_o)
    else report_failure("escalate_o dropped after it was set");

  a_stall_stable: assert property (@(posedge clk) disable iff (!cptra_rst_b)
    (out_valid_o && !out_ready_i) |=> $stable(out_req_o))
    else report_failure("out_req_o changed while the beat was stalled");

  // --------------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------------

  task automatic send_cmd(input logic [7:0] code);
    logic ready_seen;
    @(posedge clk);
    cmd_valid_i <= 1'b1;
    cmd_code    <= code;
    do begin
      @(negedge clk);
      ready_seen = cmd_ready_o;
      @(posedge clk);
    end while (!ready_seen);
    cmd_valid_i <= 1'b0;
  endtask

  task automatic send_write(input logic [31:0] wr_addr, input logic [31:0] wr_data,
                            input logic [31:0] wr_user);
    logic ready_seen;
    @(posedge clk);
    in_valid_i <= 1'b1;
    in_req_i   <= '{addr: wr_addr, data: wr_data, user: wr_user};
    do begin
      @(negedge clk);
      ready_seen = in_ready_o;
      @(posedge clk);
    end while (!ready_seen);
    in_valid_i <= 1'b0;
  endtask

  initial begin
    #(TB_WATCHDOG_NS);
    $display("ERROR test=%s: watchdog expired before the tests finished", test_name);
    $display("CHECKS FAILED");
    $fatal(1, "timeout");
  end

  initial begin
    logic [7:0]  flag_codes [6];
    logic [7:0]  code;
    logic [31:0] addr;
    flag_codes = '{8'h04, 8'h05, 8'h06, 8'h07, 8'h11, 8'h12};
    cptra_rst_b   = 1'b0;
    cmd_valid_i   = 1'b0;
    cmd_code      = 8'h00;
    zeroize_ppd_i = 1'b0;
    in_valid_i    = 1'b0;
    in_req_i      = '0;
    out_ready_i   = 1'b1;
    bp_en         = 1'b0;
    test_name     = "reset";
    void'($urandom(TB_SEED));

    repeat (TB_RST_CYCLES) @(posedge clk);
    cptra_rst_b <= 1'b1;
    repeat (2) @(posedge clk);

    test_name = "user_override";
    for (int unsigned i = 0; i < TB_N_USER_WR; i++) begin
      if (i == 0) send_cmd(8'h01);
      if (i == TB_N_USER_WR / 3) send_cmd(8'h02);
      if (i == 2 * TB_N_USER_WR / 3) send_cmd(8'h03);
      send_write($urandom, $urandom, $urandom);
    end

    test_name = "fault_injection";
    for (int unsigned i = 0; i < TB_N_FAULT_WR; i++) begin
      if (i == TB_N_FAULT_WR / 4) send_cmd(8'h0C);
      addr = (i % 2 == 0) ? svc_pkg::SVC_FAULT_ADDR : $urandom;
      send_write(addr, $urandom, $urandom);
    end

    test_name = "flags";
    for (int unsigned i = 0; i < TB_N_FLAG_CMD; i++) begin
      send_cmd(flag_codes[$urandom_range(0, 5)]);
      repeat ($urandom_range(0, 2)) @(posedge clk);
    end

    test_name = "clock_select";
    for (int unsigned i = 0; i < TB_N_CLK_CMD; i++) begin
      if ($urandom_range(0, 3) == 0) begin
        code = 8'($urandom_range(8'h13, 8'hFF));
      end else begin
        code = 8'(8'h08 + $urandom_range(0, 3));
      end
      send_cmd(code);
    end

    test_name = "domain_reset";
    for (int unsigned i = 0; i < TB_N_DOM_RST; i++) begin
      send_cmd(8'h10);
      // The next transfer has to wait out the hold
      if (i % 2 == 0) begin
        send_write($urandom, $urandom, $urandom);
      end else begin
        send_cmd(8'(8'h08 + $urandom_range(0, 3)));
      end
      repeat (3) @(posedge clk);
    end

    test_name = "back_pressure";
    bp_en <= 1'b1;
    for (int unsigned i = 0; i < TB_N_BP_WR; i++) begin
      addr = ($urandom_range(0, 3) == 0) ? svc_pkg::SVC_FAULT_ADDR : $urandom;
      send_write(addr, $urandom, $urandom);
    end
    bp_en <= 1'b0;

    repeat (4) @(posedge clk);
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule
